// ==== compile.f ====
replica_pkg.sv
exp.sv
exp_seq.sv
rng_lfsr.sv
accept_judge.sv
exchange_unit.sv
tb_exchange.sv

// ==== tb_exchange.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_exchange;

    localparam int          nbeta_t  = 1;                  // replica 0 at beta 1
    localparam int          step_t   = 1;                  // ladder spans beta 1 .. 16
    localparam logic [31:0] seed_t   = 32'hace1_2469;      // LFSR start state
    localparam int          n_req    = 300;
    localparam int          lat      = replica_pkg::n_terms + 5;   // req sampled to ack high
    localparam int          wait_max = 100;                // cycles before a wait gives up
    localparam longint      one_y    = longint'(1) << replica_pkg::y_frac;       // 1.0 in .23
    localparam longint      half_x   = longint'(1) << (replica_pkg::x_frac - 1); // 0.5 in .17
    localparam longint      lim_x    =
        longint'(replica_pkg::x_limit) << replica_pkg::x_frac;                // 8.0 in .17

    logic                                     clk;
    logic                                     rst;
    logic                                     req;
    logic signed [replica_pkg::x_w-1:0]       x;
    logic        [replica_pkg::base_log-1:0]  base_id;
    wire                                      ack;
    wire  signed [replica_pkg::y_w-1:0]       y;
    wire                                      accept;

    integer      seed;
    logic [31:0] lfsr_m;                                   // threshold generator model
    int          n_clamp;                                  // scaled argument below -8
    int          n_zero;                                   // results forced to zero
    int          n_sure;                                   // small positive, certain accept

    exchange_unit #(
        .nbeta     (nbeta_t),
        .step      (step_t),
        .lfsr_seed (seed_t)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .x       (x),
        .base_id (base_id),
        .ack     (ack),
        .y       (y),
        .accept  (accept)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                            // 100 ns period
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // failure reporting
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped");
    endtask

    task automatic compare(input string name, input longint got, input longint want);
        if (got != want) begin
            $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, want);
            abort_run();
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout: %s", what);
        abort_run();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic longint sext(input longint v, input int w);
        return (v <<< (64 - w)) >>> (64 - w);             // keep w bits, sign extend
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) n = n ^ 32'h8020_0003;                   // galois taps
        return n;
    endfunction

    // horner series 1 + x/15 (1 + x/14 (...)), all in fixed point
    task automatic predict(input longint xv, input longint id,
                           output longint arg, output longint ym);
        longint beta;
        longint xt;
        longint r;
        longint z;
        longint yv;
        bit     neg;
        beta = sext(nbeta_t + step_t * id, replica_pkg::recip_w + 1);
        arg  = sext(xv * beta, 32);                        // scaled argument, .17
        neg  = (arg < -lim_x);                             // out of range clamps
        xt   = sext(arg, replica_pkg::x_w);                // held copy is truncated
        yv   = one_y;                                      // innermost term
        for (int k = replica_pkg::n_terms; k >= 1; k--) begin
            r  = (longint'(1) << replica_pkg::recip_frac) / k;
            z  = sext(sext(xt * r, 38) >>> 18, replica_pkg::recip_w + 1);   // x/k, .14
            yv = sext(one_y + ((sext(yv, replica_pkg::y_w - 2) * z) >>> 14),
                      replica_pkg::y_w);
            if (yv < 0) neg = 1'b1;                        // any negative step clamps
        end
        ym = neg ? 0 : yv;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        longint      arg;
        longint      ym;
        logic        acc_m;
        int          cycles;
        int          hold;
        int          gap;
        int          xi;
        logic [31:0] r;
        logic [31:0] v;
        seed    = 32'h01c178b2;
        rst     = 1'b1;
        req     = 1'b0;
        x       = '0;
        base_id = '0;
        lfsr_m  = seed_t;
        n_clamp = 0;
        n_zero  = 0;
        n_sure  = 0;
        repeat (10) @(posedge clk);
        #5 rst = 1'b0;

        repeat (3) begin                                   // quiet after reset
            @(posedge clk);
            #5;
            compare("ack", ack, 0);
            compare("accept", accept, 0);
        end

        for (int i = 0; i < n_req; i++) begin
            r = $random(seed);
            v = $random(seed);
            case (r[1:0])
                2'd0:    xi = int'($signed(v[20:0]));      // anything, wraps too
                2'd1:    xi = -int'(v[16:0]);              // -1 .. 0, scaled to -16
                2'd2:    xi = int'($signed(v[12:0]));      // small, either sign
                default: xi = int'(v[11:0]);               // small positive
            endcase
            gap = r[10:9];
            repeat (gap) begin
                @(posedge clk);
                #5;
            end
            x       = xi[replica_pkg::x_w-1:0];
            base_id = r[7:4];
            req     = 1'b1;
            predict(xi, base_id, arg, ym);
            acc_m  = (ym >= one_y) || (longint'(lfsr_m[22:0]) < ym);
            lfsr_m = lfsr_next(lfsr_m);                    // one step per decision

            @(posedge clk);                                // edge that samples req
            #5;
            cycles = 0;
            while (!ack) begin
                if (cycles >= wait_max) timed_out("ack never rose after a request");
                @(posedge clk);
                #5;
                cycles++;
            end
            compare("ack_latency", cycles, lat);

            if (arg < -lim_x) begin
                compare("y_range_clamp", y, 0);
                n_clamp++;
            end
            if (ym == 0) begin
                compare("accept_on_zero", accept, 0);      // zero never wins
                n_zero++;
            end
            if (arg >= 0 && arg <= half_x) begin
                compare("y_at_least_one", (y >= one_y), 1);
                compare("accept_certain", accept, 1);
                n_sure++;
            end
            compare("y", y, ym);
            compare("accept", accept, acc_m);

            hold = r[13:11] % 5;                           // requester stalls
            repeat (hold) begin
                @(posedge clk);
                #5;
                compare("ack", ack, 1);
                compare("y", y, ym);
                compare("accept", accept, acc_m);
            end
            req    = 1'b0;
            cycles = 0;
            while (ack) begin
                if (cycles >= wait_max) timed_out("ack stayed high after req dropped");
                @(posedge clk);
                #5;
                cycles++;
            end
            compare("ack_release", cycles, 1);             // one cycle after req seen low
        end

        $display("%0d requests, %0d range clamps, %0d zero results, %0d certain accepts",
                 n_req, n_clamp, n_zero, n_sure);
        if (n_clamp == 0 || n_zero == 0 || n_sure == 0) begin
            $display("stimulus missed the clamp, zero or certain accept cases");
            abort_run();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== exchange_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module exchange_unit #(
    parameter int          nbeta     = 1,                  // beta of replica 0
    parameter int          step      = 1,                  // beta step per replica
    parameter logic [31:0] lfsr_seed = 32'h0000_0001       // nonzero LFSR start
) (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  req,
    input  wire signed [replica_pkg::x_w-1:0]    x,         // .17 energy term
    input  wire        [replica_pkg::base_log-1:0] base_id, // replica index
    output logic                                 ack,
    output logic signed [replica_pkg::y_w-1:0]   y,         // .23 acceptance probability
    output logic                                 accept
);

    logic                                init;              // seq -> exp
    logic                                run;
    logic [replica_pkg::recip_w-1:0]     recip;
    logic                                done;              // seq -> judge
    logic                                decided;           // judge -> seq
    logic                                take;              // judge -> lfsr
    logic signed [replica_pkg::y_w-1:0]  y_exp;             // exp -> judge
    logic [31:0]                         rnd;               // lfsr -> judge

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control and evaluation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    exp_seq u_seq (
        .clk     (clk),
        .rst     (rst),
        .req     (req),
        .ack     (ack),
        .init    (init),
        .run     (run),
        .recip   (recip),
        .done    (done),
        .decided (decided)
    );

    exp #(
        .nbeta (nbeta),
        .step  (step)
    ) u_exp (
        .clk     (clk),
        .base_id (base_id),                                 // sampled on init
        .x       (x),
        .y       (y_exp),
        .init    (init),
        .run     (run),
        .recip   (recip)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decision
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    rng_lfsr #(
        .lfsr_seed (lfsr_seed)
    ) u_rng (
        .clk  (clk),
        .rst  (rst),
        .take (take),
        .rnd  (rnd)
    );

    accept_judge u_judge (
        .clk     (clk),
        .rst     (rst),
        .done    (done),
        .y_in    (y_exp),
        .rnd     (rnd),
        .y       (y),
        .accept  (accept),
        .take    (take),
        .decided (decided)
    );

endmodule

`default_nettype wire

// ==== accept_judge.sv ====
`timescale 1ns/10ps
`default_nettype none

module accept_judge (
    input  wire                                  clk,
    input  wire                                  rst,
    input  wire                                  done,      // exp result is final
    input  wire signed [replica_pkg::y_w-1:0]    y_in,      // .23 from exp
    input  wire        [31:0]                    rnd,       // threshold source
    output logic signed [replica_pkg::y_w-1:0]   y,         // held through the handshake
    output logic                                 accept,
    output logic                                 take,      // advance the LFSR
    output logic                                 decided    // result on outputs
);

    localparam logic signed [replica_pkg::y_w-1:0] one_y =
        replica_pkg::y_w'(1) <<< replica_pkg::y_frac;       // 1.0 in .23

    logic signed [replica_pkg::y_w-1:0] thresh;             // uniform in [0, 1)
    logic                               verdict;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // metropolis rule
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        thresh  = $signed({{(replica_pkg::y_w - replica_pkg::y_frac){1'b0}},
                           rnd[replica_pkg::y_frac-1:0]});
        // probability at or above one always accepts
        verdict = (y_in >= one_y) || (thresh < y_in);       // y of zero never passes
    end

    always_ff @(posedge clk) begin
        if (done) y <= y_in;                                // held exp result

        if (rst) begin
            accept  <= 1'b0;
            take    <= 1'b0;
            decided <= 1'b0;
        end else begin
            if (done) accept <= verdict;
            take    <= done;                                // once per decision
            decided <= done;
        end
    end

endmodule

`default_nettype wire

// ==== rng_lfsr.sv ====
`timescale 1ns/10ps
`default_nettype none

module rng_lfsr #(
    parameter logic [31:0] lfsr_seed = 32'h0000_0001      // must be nonzero
) (
    input  wire          clk,
    input  wire          rst,
    input  wire          take,                            // one pulse per decision
    output logic [31:0]  rnd                              // current state, used as threshold
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // galois LFSR, shifts right
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [31:0] mask = 32'h8020_0003;         // taps 32 22 2 1

    logic [31:0] nxt;

    always_comb begin
        nxt = rnd >> 1;
        if (rnd[0]) nxt = nxt ^ mask;                     // feedback from lsb
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rnd <= lfsr_seed;
        end else if (take) begin
            rnd <= nxt;                                   // advance after the compare used rnd
        end
    end

endmodule

`default_nettype wire

// ==== exp_seq.sv ====
`timescale 1ns/10ps
`default_nettype none

module exp_seq (
    input  wire                                 clk,
    input  wire                                 rst,
    input  wire                                 req,      // four phase request
    output logic                                ack,
    output logic                                init,     // one cycle, loads x and beta
    output logic                                run,      // n_terms cycles
    output logic [replica_pkg::recip_w-1:0]     recip,    // 1/k, .15
    output logic                                done,     // y of exp is final
    input  wire                                 decided   // judge has latched its result
);

    localparam logic [replica_pkg::cnt_w-1:0] last_term =
        replica_pkg::cnt_w'(replica_pkg::n_terms - 1);
    localparam logic [replica_pkg::cnt_w-1:0] tail_last =
        replica_pkg::cnt_w'(1);                           // two tail cycles

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reciprocal table, entry i holds 1/(n_terms-i)
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [replica_pkg::recip_w-1:0] recip_tab_t [replica_pkg::n_terms];

    function automatic recip_tab_t make_recip_tab();
        recip_tab_t tab;
        for (int i = 0; i < replica_pkg::n_terms; i++) begin
            tab[i] = replica_pkg::recip_w'((1 << replica_pkg::recip_frac) /
                                           (replica_pkg::n_terms - i));
        end
        return tab;
    endfunction

    localparam recip_tab_t recip_tab = make_recip_tab();

    typedef enum logic [2:0] {
        st_idle,                                          // waiting for req
        st_init,                                          // init pulse
        st_run,                                           // stream 1/15 .. 1/1
        st_tail,                                          // exp finishing last term
        st_wait,                                          // judge deciding
        st_ack                                            // holding ack until req drops
    } state_t;

    state_t                          state;
    logic [replica_pkg::cnt_w-1:0]   cnt;                 // term / tail counter

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            cnt   <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;                                 // pulse by default
            case (state)
                st_idle: begin
                    if (req) state <= st_init;            // only seen while ack is low
                end
                st_init: begin
                    cnt   <= '0;
                    state <= st_run;
                end
                st_run: begin
                    if (cnt == last_term) begin
                        cnt   <= '0;
                        state <= st_tail;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_tail: begin
                    if (cnt == tail_last) begin
                        cnt   <= '0;
                        done  <= 1'b1;                    // exp registers y on this edge
                        state <= st_wait;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_wait: begin
                    if (decided) state <= st_ack;
                end
                st_ack: begin
                    if (!req) state <= st_idle;           // ack falls next cycle
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign init  = (state == st_init);
    assign run   = (state == st_run);
    assign ack   = (state == st_ack);
    assign recip = run ? recip_tab[cnt] : '0;             // 0 in the trailing cycle

endmodule

`default_nettype wire

// ==== exp.sv ====
`timescale 1ns/10ps
`default_nettype none

module exp #(
    parameter int nbeta = 1,                                 // beta of replica 0
    parameter int step  = 1                                  // beta increment per replica
) (
    input  wire                                  clk,
    input  wire        [replica_pkg::base_log-1:0] base_id,
    input  wire signed [replica_pkg::x_w-1:0]     x,         // .17
    output logic signed [replica_pkg::y_w-1:0]    y,         // .23, never negative
    input  wire                                  init,
    input  wire                                  run,
    input  wire        [replica_pkg::recip_w-1:0] recip      // .15
);

    localparam int a_w  = replica_pkg::y_w - 2;              // y operand, top bits of y dropped
    localparam int b_w  = replica_pkg::recip_w + 1;          // beta / recip / z operand
    localparam int xx_w = 32;                                // scaled argument before hold
    localparam int p_w  = a_w + b_w;                         // full horner product
    localparam int zr_w = replica_pkg::x_w + replica_pkg::recip_w;
    localparam int z_sh = replica_pkg::x_frac + replica_pkg::recip_frac - replica_pkg::z_frac;

    // 1.0 in the .37 product domain
    localparam logic signed [p_w-1:0] one_p =
        p_w'(1) <<< (replica_pkg::z_frac + replica_pkg::y_frac);

    logic                     init_l;                        // first run cycle marker for yy
    logic                     run_l;                         // trailing iteration after run
    logic signed [a_w-1:0]    a0, a1;                        // multiplier operand pair a
    logic signed [b_w-1:0]    b0, b1;                        // multiplier operand pair b
    logic                     nega;                          // sticky negative / range flag

    logic signed [xx_w-1:0]   xx;                            // x * beta, .17
    logic signed [zr_w-1:0]   zprod;                         // xx * 1/k before scaling
    logic signed [b_w-1:0]    zz;                            // x/k, .14
    logic signed [p_w-1:0]    horner;                        // 1 + y * z, .37
    logic signed [replica_pkg::y_w-1:0] yy;                  // running series value, .23

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        init_l <= init;
        run_l  <= run;

        if (init) begin
            a0   <= x;                                       // sign extended .17
            b0   <= b_w'(nbeta + step * int'(base_id));      // replica beta
            nega <= 1'b0;
        end else if (run || run_l) begin
            a1 <= $signed(yy[a_w-1:0]);                      // feed y back
            b1 <= zz;
            if (!run_l) begin
                // first run cycle, scaled argument is ready on xx
                a0 <= $signed(xx[replica_pkg::x_w-1:0]);     // hold truncated .17
                if (xx < -(replica_pkg::x_limit <<< replica_pkg::x_frac)) begin
                    nega <= 1'b1;                            // argument below -8
                end
            end
            b0 <= {1'b0, recip};                             // next 1/k, 0 on the tail
            if (yy < 0) nega <= 1'b1;                        // series went negative
        end

        if (nega || yy < 0) y <= '0;                         // clamp
        else                y <= yy;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // shared multipliers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        xx     = xx_w'(a0 * b0);                             // x * beta on the init product
        zprod  = zr_w'(a0 * b0);                             // xx * recip during run
        zz     = b_w'(zprod >>> z_sh);                       // down to .14
        horner = one_p + p_w'(a1 * b1);
        if (init_l) yy = '0;                                 // series restarts
        else        yy = replica_pkg::y_w'(horner >>> replica_pkg::z_frac);
    end

endmodule

`default_nettype wire

// ==== replica_pkg.sv ====
`default_nettype none

package replica_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // replica addressing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int base_log = 4;       // 16 replicas in the ladder

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fixed point formats
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int x_w        = 21;    // signed energy term
    localparam int x_frac     = 17;    // x and scaled argument are .17
    localparam int x_limit    = 8;     // scaled argument below -8 clamps to zero

    localparam int y_w        = 27;    // signed exp result
    localparam int y_frac     = 23;    // y is .23, so 1.0 is 2^23

    localparam int recip_w    = 17;    // unsigned 1/k entry
    localparam int recip_frac = 15;    // .15, 1/1 needs the top bit

    localparam int z_frac     = 14;    // per-term factor x/k is .14

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // series control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int n_terms    = 15;    // highest taylor term, runs 1/15 .. 1/1
    localparam int cnt_w      = 4;     // term counter, holds 0 .. n_terms-1

endpackage

`default_nettype wire
